//--- source/chroni_pkg.sv
package chroni_pkg;

   localparam int vram_addr_w = 17;
   typedef logic [vram_addr_w-1:0] vram_addr_t;

   localparam int text_columns = 4;
   typedef logic [1:0] col_idx_t;
   typedef logic [4:0] pixel_x_t;
   typedef logic [3:0] color_t;

   localparam int vram_read_latency = 2;   // address to data, in cycles
   localparam int font_rows = 8;

   // register window at 0x900x
   localparam logic [11:0] reg_window_base = 12'h900;
   localparam logic [3:0]  reg_dl_lo     = 4'd0;
   localparam logic [3:0]  reg_dl_hi     = 4'd1;
   localparam logic [3:0]  reg_vram_lo   = 4'd6;
   localparam logic [3:0]  reg_vram_mid  = 4'd7;
   localparam logic [3:0]  reg_vram_hi   = 4'd8;
   localparam logic [3:0]  reg_vram_data = 4'd9;

   localparam logic [3:0] dl_end = 4'd1;
   localparam int dl_lms_bit = 6;

   typedef struct packed {
      logic [15:0] addr;
      logic [7:0]  data;
   } cpu_write_t;

   typedef struct packed {
      vram_addr_t addr;
      logic [7:0] data;
   } vram_write_t;

   typedef struct packed {
      logic [7:0] bits;
      color_t     on_color;
      color_t     off_color;
      pixel_x_t   x;
   } font_job_t;

   typedef struct packed {
      pixel_x_t x;
      color_t   color;
   } pixel_t;

endpackage

//--- source/chroni_registers.sv
`timescale 1ns/1ps

module chroni_registers (
   input  logic                    sys_clk,
   input  logic                    rst,
   input  chroni_pkg::cpu_write_t  cpu_wr,
   input  logic                    cpu_wr_en,
   output chroni_pkg::vram_addr_t  dl_base,
   output chroni_pkg::vram_write_t vram_wr,
   output logic                    vram_wr_en
);
   import chroni_pkg::*;

   logic [15:0] dl_hold;      // display list base bits 16..1
   vram_addr_t  port_addr;
   logic        reg_sel;

   assign reg_sel = cpu_wr_en && (cpu_wr.addr[15:4] == reg_window_base);
   assign dl_base = {dl_hold, 1'b0};   // list always starts on an even address

   always_ff @(posedge sys_clk) begin
      if (rst) begin
         dl_hold <= '0;
         port_addr <= '0;
         vram_wr_en <= 1'b0;
      end else begin
         vram_wr_en <= 1'b0;
         if (reg_sel) begin
            case (cpu_wr.addr[3:0])
               reg_dl_lo:    dl_hold[7:0] <= cpu_wr.data;
               reg_dl_hi:    dl_hold[15:8] <= cpu_wr.data;
               reg_vram_lo:  port_addr[7:0] <= cpu_wr.data;
               reg_vram_mid: port_addr[15:8] <= cpu_wr.data;
               reg_vram_hi:  port_addr[16] <= cpu_wr.data[0];
               reg_vram_data: begin
                  vram_wr.addr <= port_addr;
                  vram_wr.data <= cpu_wr.data;
                  vram_wr_en <= 1'b1;
                  port_addr <= port_addr + 1'b1;   // wraps at the top of vram
               end
               default: ;
            endcase
         end
      end
   end

endmodule

//--- source/chroni_vram.sv
`timescale 1ns/1ps

module chroni_vram (
   input  logic                    sys_clk,
   input  chroni_pkg::vram_write_t vram_wr,
   input  logic                    vram_wr_en,
   input  chroni_pkg::vram_addr_t  dl_rd_addr,
   input  chroni_pkg::vram_addr_t  fetch_rd_addr,
   input  logic                    dl_reading,
   output logic [7:0]              rd_data
);
   import chroni_pkg::*;

   logic [7:0] mem [0:(1 << vram_addr_w) - 1];
   vram_addr_t rd_addr_q;

   always_ff @(posedge sys_clk) begin
      if (vram_wr_en)
         mem[vram_wr.addr] <= vram_wr.data;
   end

   // registered address then registered data, two cycles in all
   always_ff @(posedge sys_clk) begin
      rd_addr_q <= dl_reading ? dl_rd_addr : fetch_rd_addr;
      rd_data <= mem[rd_addr_q];
   end

endmodule

//--- source/display_list_processor.sv
`timescale 1ns/1ps

module display_list_processor (
   input  logic                   sys_clk,
   input  logic                   rst,
   input  logic                   frame_start,
   input  logic                   line_start,
   input  chroni_pkg::vram_addr_t dl_base,
   input  logic [7:0]             rd_data,
   output chroni_pkg::vram_addr_t dl_rd_addr,
   output logic                   dl_reading,
   output logic                   row_render,
   output chroni_pkg::vram_addr_t text_base,
   output chroni_pkg::vram_addr_t attr_base,
   output logic                   lms_loaded
);
   import chroni_pkg::*;

   typedef enum logic [2:0] {
      dl_idle,
      dl_read,
      dl_wait,
      dl_lms,
      dl_lms_wait,
      dl_exec
   } dl_state_t;

   dl_state_t  state;
   logic [3:0] lines_left;   // scanlines still owed by the current row
   logic       ended;
   logic       lms_pend;
   logic [2:0] lms_part;
   logic [1:0] wait_cnt;

   // dl_rd_addr doubles as the list pointer and is presented in the read states
   assign dl_reading = (state != dl_idle) && (state != dl_exec);

   always_ff @(posedge sys_clk) begin
      row_render <= 1'b0;
      lms_loaded <= 1'b0;
      if (rst) begin
         text_base <= '0;
         attr_base <= '0;
      end
      if (rst || frame_start) begin
         state <= dl_idle;
         dl_rd_addr <= dl_base;
         lines_left <= '0;
         ended <= 1'b0;
         lms_pend <= 1'b0;
      end else if (line_start && state == dl_idle) begin
         if (lines_left != '0) begin
            lines_left <= lines_left - 1'b1;
            row_render <= 1'b1;
         end else if (!ended) begin
            state <= dl_read;
         end
      end else begin
         case (state)
            dl_read, dl_lms: begin
               dl_rd_addr <= dl_rd_addr + 1'b1;
               wait_cnt <= 2'(vram_read_latency - 1);
               state <= (state == dl_read) ? dl_wait : dl_lms_wait;
            end
            dl_wait:
               if (wait_cnt != '0) begin
                  wait_cnt <= wait_cnt - 1'b1;
               end else if (rd_data[3:0] == dl_end) begin
                  ended <= 1'b1;
                  state <= dl_idle;
               end else if (rd_data[dl_lms_bit]) begin
                  lms_part <= '0;
                  state <= dl_lms;
               end else begin
                  state <= dl_exec;
               end
            dl_lms_wait:
               if (wait_cnt != '0) begin
                  wait_cnt <= wait_cnt - 1'b1;
               end else begin
                  case (lms_part)   // little endian, text base then attr base
                     3'd0: text_base[7:0] <= rd_data;
                     3'd1: text_base[15:8] <= rd_data;
                     3'd2: text_base[16] <= rd_data[0];
                     3'd3: attr_base[7:0] <= rd_data;
                     3'd4: attr_base[15:8] <= rd_data;
                     default: attr_base[16] <= rd_data[0];
                  endcase
                  lms_part <= lms_part + 1'b1;
                  if (lms_part == 3'd5) begin
                     lms_pend <= 1'b1;
                     state <= dl_exec;
                  end else begin
                     state <= dl_lms;
                  end
               end
            dl_exec: begin
               row_render <= 1'b1;
               lms_loaded <= lms_pend;
               lms_pend <= 1'b0;
               lines_left <= 4'(font_rows - 1);   // first scanline goes out now
               state <= dl_idle;
            end
            default: ;
         endcase
      end
   end

endmodule

//--- source/text_line_fetcher.sv
`timescale 1ns/1ps

module text_line_fetcher (
   input  logic                   sys_clk,
   input  logic                   rst,
   input  logic                   frame_start,
   input  logic                   row_render,
   input  chroni_pkg::vram_addr_t text_base,
   input  chroni_pkg::vram_addr_t attr_base,
   input  logic                   lms_loaded,
   input  logic [7:0]             rd_data,
   output chroni_pkg::vram_addr_t fetch_rd_addr,
   output chroni_pkg::font_job_t  job,
   output logic                   job_valid,
   input  logic                   ser_busy
);
   import chroni_pkg::*;

   typedef enum logic [2:0] {
      f_idle,
      f_load,
      f_font,
      f_wait,
      f_issue
   } fetch_state_t;

   fetch_state_t state;
   vram_addr_t   row_text;
   vram_addr_t   row_attr;
   logic [2:0]   font_scan;
   col_idx_t     col;
   logic [3:0]   ld_cnt;
   logic [3:0]   ld_idx;
   logic [1:0]   wait_cnt;
   logic [7:0]   text_buf [text_columns];
   logic [7:0]   attr_buf [text_columns];

   // slot whose byte comes back this cycle, text slots first
   assign ld_idx = ld_cnt - 4'(vram_read_latency + 1);

   always_ff @(posedge sys_clk) begin
      job_valid <= 1'b0;
      if (rst || frame_start) begin
         state <= f_idle;
         font_scan <= '0;
         row_text <= text_base;
         row_attr <= attr_base;
      end else if (row_render) begin
         if (lms_loaded) begin
            row_text <= text_base;
            row_attr <= attr_base;
         end
         col <= '0;
         ld_cnt <= '0;
         state <= (font_scan == '0) ? f_load : f_font;   // buffers only refill on scanline 0
      end else begin
         case (state)
            f_load: begin
               // one address per cycle, reads overlap
               if (ld_cnt < 4'(2 * text_columns))
                  fetch_rd_addr <= (ld_cnt[2] ? row_attr : row_text) + vram_addr_t'(ld_cnt[1:0]);
               if (ld_cnt >= 4'(vram_read_latency + 1)) begin
                  if (ld_idx[2])
                     attr_buf[ld_idx[1:0]] <= rd_data;
                  else
                     text_buf[ld_idx[1:0]] <= rd_data;
               end
               if (ld_cnt == 4'(2 * text_columns + vram_read_latency))
                  state <= f_font;
               ld_cnt <= ld_cnt + 1'b1;
            end
            f_font: begin
               fetch_rd_addr <= vram_addr_t'({text_buf[col], font_scan});
               wait_cnt <= 2'(vram_read_latency);
               state <= f_wait;
            end
            f_wait:
               if (wait_cnt == '0) begin
                  job.bits <= rd_data;
                  job.on_color <= attr_buf[col][3:0];
                  job.off_color <= attr_buf[col][7:4];
                  job.x <= {col, 3'b000};
                  state <= f_issue;
               end else begin
                  wait_cnt <= wait_cnt - 1'b1;
               end
            f_issue:
               if (!ser_busy) begin
                  job_valid <= 1'b1;
                  if (col == col_idx_t'(text_columns - 1)) begin
                     font_scan <= font_scan + 1'b1;
                     if (font_scan == 3'(font_rows - 1)) begin   // next text row
                        row_text <= row_text + vram_addr_t'(text_columns);
                        row_attr <= row_attr + vram_addr_t'(text_columns);
                     end
                     state <= f_idle;
                  end else begin
                     col <= col + 1'b1;
                     state <= f_font;
                  end
               end
            default: ;
         endcase
      end
   end

endmodule

//--- source/pixel_serializer.sv
`timescale 1ns/1ps

module pixel_serializer (
   input  logic                  sys_clk,
   input  logic                  rst,
   input  chroni_pkg::font_job_t job,
   input  logic                  job_valid,
   output logic                  ser_busy,
   output chroni_pkg::pixel_t    pixel,
   output logic                  pixel_valid
);
   import chroni_pkg::*;

   font_job_t  cur;    // bits shift out msb first, x steps per pixel
   logic [3:0] left;

   assign ser_busy = (left != '0);

   always_ff @(posedge sys_clk) begin
      if (rst) begin
         left <= '0;
         pixel_valid <= 1'b0;
      end else begin
         pixel_valid <= ser_busy;
         if (job_valid && !ser_busy) begin
            cur <= job;
            left <= 4'd8;   // one pixel per font bit
         end else if (ser_busy) begin
            pixel.x <= cur.x;
            pixel.color <= cur.bits[7] ? cur.on_color : cur.off_color;
            cur.bits <= {cur.bits[6:0], 1'b0};
            cur.x <= cur.x + 1'b1;
            left <= left - 1'b1;
         end
      end
   end

endmodule

//--- source/chroni.sv
`timescale 1ns/1ps

module chroni (
   input  logic                   sys_clk,
   input  logic                   rst,
   input  chroni_pkg::cpu_write_t cpu_wr,
   input  logic                   cpu_wr_en,
   input  logic                   frame_start,
   input  logic                   line_start,
   output chroni_pkg::pixel_t     pixel,
   output logic                   pixel_valid
);
   import chroni_pkg::*;

   vram_write_t vram_wr;
   logic        vram_wr_en;
   vram_addr_t  dl_base;
   vram_addr_t  dl_rd_addr;
   vram_addr_t  fetch_rd_addr;
   logic        dl_reading;
   logic [7:0]  rd_data;
   logic        row_render;
   vram_addr_t  text_base;
   vram_addr_t  attr_base;
   logic        lms_loaded;
   font_job_t   job;
   logic        job_valid;
   logic        ser_busy;

   chroni_registers chroni_registers_inst (
      .sys_clk    (sys_clk),
      .rst        (rst),
      .cpu_wr     (cpu_wr),
      .cpu_wr_en  (cpu_wr_en),
      .dl_base    (dl_base),
      .vram_wr    (vram_wr),
      .vram_wr_en (vram_wr_en)
   );

   chroni_vram chroni_vram_inst (
      .sys_clk       (sys_clk),
      .vram_wr       (vram_wr),
      .vram_wr_en    (vram_wr_en),
      .dl_rd_addr    (dl_rd_addr),
      .fetch_rd_addr (fetch_rd_addr),
      .dl_reading    (dl_reading),
      .rd_data       (rd_data)
   );

   display_list_processor display_list_processor_inst (
      .sys_clk     (sys_clk),
      .rst         (rst),
      .frame_start (frame_start),
      .line_start  (line_start),
      .dl_base     (dl_base),
      .rd_data     (rd_data),
      .dl_rd_addr  (dl_rd_addr),
      .dl_reading  (dl_reading),
      .row_render  (row_render),
      .text_base   (text_base),
      .attr_base   (attr_base),
      .lms_loaded  (lms_loaded)
   );

   text_line_fetcher text_line_fetcher_inst (
      .sys_clk       (sys_clk),
      .rst           (rst),
      .frame_start   (frame_start),
      .row_render    (row_render),
      .text_base     (text_base),
      .attr_base     (attr_base),
      .lms_loaded    (lms_loaded),
      .rd_data       (rd_data),
      .fetch_rd_addr (fetch_rd_addr),
      .job           (job),
      .job_valid     (job_valid),
      .ser_busy      (ser_busy)
   );

   pixel_serializer pixel_serializer_inst (
      .sys_clk     (sys_clk),
      .rst         (rst),
      .job         (job),
      .job_valid   (job_valid),
      .ser_busy    (ser_busy),
      .pixel       (pixel),
      .pixel_valid (pixel_valid)
   );

endmodule

//--- tests/chroni_tb.sv
`timescale 1ns/1ps

module chroni_tb;
   import chroni_pkg::*;

   typedef struct packed {
      logic [7:0]   kind;     // w, l, n or f
      logic [3:0]   offset;
      logic [7:0]   data;
      logic [127:0] colors;   // pixel x = 0 sits in the top nibble
   } golden_rec_t;

   logic       sys_clk;
   logic       rst;
   cpu_write_t cpu_wr;
   logic       cpu_wr_en;
   logic       frame_start;
   logic       line_start;
   pixel_t     pixel;
   logic       pixel_valid;

   golden_rec_t records[$];
   int          write_count = 0;
   int          line_count = 0;
   int          cycle_count = 0;
   int          cycle_limit = 0;   // zero until the golden file is loaded

   chroni chroni_inst (
      .sys_clk     (sys_clk),
      .rst         (rst),
      .cpu_wr      (cpu_wr),
      .cpu_wr_en   (cpu_wr_en),
      .frame_start (frame_start),
      .line_start  (line_start),
      .pixel       (pixel),
      .pixel_valid (pixel_valid)
   );

   initial begin
      sys_clk = 1'b0;
      forever #20 sys_clk = ~sys_clk;
   end

   task automatic fail_run(input string msg);
      $display("%s", msg);
      $display("TESTS FAILED");
      $fatal(1);
   endtask

   task automatic check_value(input string name, input logic [31:0] actual,
                              input logic [31:0] expected);
      if (actual !== expected)
         fail_run($sformatf("[FAIL] %s: got 0x%0h, expected 0x%0h", name, actual, expected));
   endtask

   always @(posedge sys_clk) begin
      cycle_count <= cycle_count + 1;
      if (cycle_limit != 0 && cycle_count >= cycle_limit)
         fail_run("the run reached its cycle limit without finishing");
   end

   task automatic load_golden();
      int           fd;
      int           n;
      string        line;
      logic [7:0]   kind;
      logic [3:0]   offset;
      logic [7:0]   data;
      logic [127:0] colors;
      golden_rec_t  rec;
      fd = $fopen("tests/chroni_golden.txt", "r");
      if (fd == 0)
         fail_run("could not open tests/chroni_golden.txt");
      while (!$feof(fd)) begin
         line = "";
         void'($fgets(line, fd));
         n = $sscanf(line, "%c", kind);
         if (n == 1 && kind inside {"w", "l", "n", "f"}) begin
            rec = '0;
            rec.kind = kind;
            if (kind == "w") begin
               if ($sscanf(line, "%c %h %h", kind, offset, data) != 3)
                  fail_run("a write record in the golden file is malformed");
               rec.offset = offset;
               rec.data = data;
               write_count = write_count + 1;
            end else if (kind == "l") begin
               if ($sscanf(line, "%c %h", kind, colors) != 2)
                  fail_run("a line record in the golden file is malformed");
               rec.colors = colors;
               line_count = line_count + 1;
            end else if (kind == "n") begin
               line_count = line_count + 1;
            end
            records.push_back(rec);
         end else if (n == 1 && !(kind inside {"#", " ", "\n", 8'h0d})) begin
            fail_run("the golden file holds a record of unknown kind");
         end
      end
      $fclose(fd);
   endtask

   // one register strobe, then a few random idle cycles
   task automatic cpu_write(input logic [3:0] offset, input logic [7:0] data);
      int idle;
      @(posedge sys_clk);
      cpu_wr.addr <= {reg_window_base, offset};
      cpu_wr.data <= data;
      cpu_wr_en <= 1'b1;
      @(posedge sys_clk);
      cpu_wr_en <= 1'b0;
      idle = int'($urandom % 4);
      repeat (idle) @(posedge sys_clk);
   endtask

   task automatic pulse_frame_start();
      @(posedge sys_clk);
      frame_start <= 1'b1;
      @(posedge sys_clk);
      frame_start <= 1'b0;
   endtask

   task automatic render_line(input logic [127:0] colors, input bit expect_pixels);
      logic [127:0] remaining;
      int           count;
      remaining = colors;
      count = 0;
      @(posedge sys_clk);
      line_start <= 1'b1;
      @(posedge sys_clk);
      line_start <= 1'b0;
      repeat (200) begin
         @(negedge sys_clk);   // outputs are settled between edges
         if (pixel_valid) begin
            if (!expect_pixels)
               fail_run("a pixel came out after the end of the display list");
            if (count == 32)
               fail_run("more than 32 pixels came out on one scanline");
            check_value("pixel.x", 32'(pixel.x), count);
            check_value("pixel.color", 32'(pixel.color), 32'(remaining[127:124]));
            remaining = remaining << 4;
            count = count + 1;
         end
      end
      if (expect_pixels && count < 32)
         fail_run($sformatf("only %0d of 32 pixels came out on one scanline", count));
   endtask

   initial begin
      int i;
      rst = 1'b1;
      cpu_wr = '0;
      cpu_wr_en = 1'b0;
      frame_start = 1'b0;
      line_start = 1'b0;
      void'($urandom(32'h3e88));
      load_golden();
      cycle_limit = write_count * 8 + line_count * 220 + 100;
      repeat (5) @(posedge sys_clk);
      rst <= 1'b0;
      @(negedge sys_clk);
      check_value("pixel_valid", 32'(pixel_valid), 32'd0);
      for (i = 0; i < records.size(); i++) begin
         case (records[i].kind)
            "w": cpu_write(records[i].offset, records[i].data);
            "l": render_line(records[i].colors, 1'b1);
            "n": render_line('0, 1'b0);   // display list already ended
            default: pulse_frame_start();
         endcase
      end
      $display("TESTS PASSED");
      $finish;
   end

endmodule

//--- tests/chroni_golden.txt
# w <register offset> <data byte> | f = frame start | n = scanline with no pixels
# l <32 hex colour nibbles, leftmost pixel first>
# display list base 0x0ee, write port from 0x0ee
w 0 77
w 1 00
w 6 ee
w 7 00
w 8 00
# display list: text with lms (text 0x0f7, attr 0x0ff), text, end
w 9 42
w 9 f7
w 9 00
w 9 00
w 9 ff
w 9 00
w 9 00
w 9 02
w 9 01
# text rows at 0x0f7
w 9 21
w 9 22
w 9 22
w 9 21
w 9 22
w 9 21
w 9 21
w 9 22
# attribute rows at 0x0ff
w 9 5a
w 9 3c
w 9 90
w 9 7f
w 9 12
w 9 e4
w 9 6b
w 9 d8
# spare byte, then font of char 0x21 at 0x108 and char 0x22 at 0x110
w 9 00
w 9 81
w 9 42
w 9 24
w 9 18
w 9 f0
w 9 0f
w 9 aa
w 9 55
w 9 3c
w 9 66
w 9 c3
w 9 ff
w 9 00
w 9 99
w 9 5a
w 9 e7
f
# first text row, font scanlines 0 to 7
l A555555A33CCCC3399000099F777777F
l 5A5555A53CC33CC3900990097F7777F7
l 55A55A55CC3333CC0099990077F77F77
l 555AA555CCCCCCCC00000000777FF777
l AAAA55553333333399999999FFFF7777
l 5555AAAAC33CC33C099009907777FFFF
l A5A5A5A53C3CC3C390900909F7F7F7F7
l 5A5A5A5ACCC33CCC000990007F7F7F7F
# second text row, four bytes further on
l 112222114EEEEEE4B666666BDD8888DD
l 12211221E4EEEE4E6B6666B6D88DD88D
l 22111122EE4EE4EE66B66B6688DDDD88
l 22222222EEE44EEE666BB66688888888
l 111111114444EEEEBBBB6666DDDDDDDD
l 21122112EEEE44446666BBBB8DD88DD8
l 121221214E4E4E4EB6B6B6B6D8D88D8D
l 22211222E4E4E4E46B6B6B6B888DD888
n
f
l A555555A33CCCC3399000099F777777F

//--- list.f
source/chroni_pkg.sv
source/chroni_registers.sv
source/chroni_vram.sv
source/display_list_processor.sv
source/text_line_fetcher.sv
source/pixel_serializer.sv
source/chroni.sv
tests/chroni_tb.sv

//--- Makefile
TOP := chroni_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --top-module chroni -f list.f

sim:
	verilator --binary --timing --top-module $(TOP) -Mdir obj_dir -f list.f
	./obj_dir/V$(TOP) | tee sim.log
	@if grep -q "TESTS FAILED" sim.log; then echo "simulation reported failure"; exit 1; fi
	@grep -q "TESTS PASSED" sim.log

clean:
	rm -rf obj_dir sim.log
